// ==== compile.f ====
des_nic_pkg.sv
des_nic_input_control_unit.sv
input_block.sv
feistel_engine.sv
output_block.sv
des_nic.sv
tb_checker.sv
tb_des_nic.sv

// ==== des_nic.sv ====
`timescale 1ns/100ps
`default_nettype none

module des_nic import des_nic_pkg::*;
(
	input  wire                        clk,
	input  wire                        reset,
	input  wire  [channel_width-1:0]   input_channel_din,
	input  wire                        credit_in,              // Reply buffer returned by router
	output logic                       input_credit,           // Request buffer free again
	output logic [channel_width-1:0]   output_channel_dout,
	output logic                       output_channel_valid
);

	logic [2*channel_width-1:0] plaintext;
	logic [2*channel_width-1:0] key;
	logic [2*channel_width-1:0] ciphertext;
	logic [channel_width-3:0]   header_flit;
	logic                       transfer2pe_strobe;
	logic                       busy_engine;
	logic                       zero_credits;
	logic                       result_valid;
	logic                       result_take;

	assign input_credit = transfer2pe_strobe;   // Flit registers free once engine starts

	input_block i_input
	(
		.clk                     (clk),
		.reset                   (reset),
		.input_channel_din       (input_channel_din),
		.busy_engine_din         (busy_engine),
		.zero_credits_din        (zero_credits),
		.plaintext_dout          (plaintext),
		.key_dout                (key),
		.header_flit_dout        (header_flit),
		.transfer2pe_strobe_dout (transfer2pe_strobe)
	);

	feistel_engine i_engine
	(
		.clk          (clk),
		.reset        (reset),
		.start        (transfer2pe_strobe),
		.plaintext    (plaintext),
		.key          (key),
		.result_take  (result_take),
		.busy         (busy_engine),
		.result_valid (result_valid),
		.ciphertext   (ciphertext)
	);

	output_block i_output
	(
		.clk                  (clk),
		.reset                (reset),
		.result_valid         (result_valid),
		.ciphertext           (ciphertext),
		.header_flit_din      (header_flit),
		.credit_in            (credit_in),
		.result_take          (result_take),
		.zero_credits_dout    (zero_credits),
		.output_channel_dout  (output_channel_dout),
		.output_channel_valid (output_channel_valid)
	);

endmodule

`default_nettype wire

// ==== des_nic_input_control_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module des_nic_input_control_unit import des_nic_pkg::*;
(
	input  wire                 clk,
	input  wire                 reset,
	input  wire                 header_field_din,          // Bit 31 of the channel word
	input  wire                 busy_engine_din,
	input  wire                 zero_credits_din,
	output logic                transfer2pe_strobe_dout,   // One-cycle engine start
	output logic                write_strobe_dout,
	output logic [data_flits:0] register_enable_dout       // Bit 0 header, bits 1..4 data
);

	icu_state_t            state;
	logic [data_flits-1:0] data_enable;     // One-hot walk over the data flits
	logic                  header_enable;   // Header word on the channel while idle
	logic                  decide;          // Packet complete, start allowed if resources free
	logic                  go;

	// ##################################################
	// Enables and start decision
	// ##################################################
	assign header_enable = (state == icu_idle) && header_field_din;
	assign decide = ((state == icu_capture) && (data_enable == '0)) || (state == icu_wait);
	assign go = decide && !busy_engine_din && !zero_credits_din;   // Engine idle and a credit left

	assign register_enable_dout    = {data_enable, header_enable};
	assign write_strobe_dout       = header_enable || (data_enable != '0);
	assign transfer2pe_strobe_dout = go;   // Also returns the router's input credit

	// ##################################################
	// State register
	// ##################################################
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state       <= icu_idle;
			data_enable <= '0;
		end
		else
		begin
			case (state)
				icu_idle:
				begin
					if (header_field_din)   // Packet starts here
					begin
						state       <= icu_capture;
						data_enable <= data_flits'(1);   // First data flit next cycle
					end
				end
				icu_capture:
				begin
					data_enable <= data_enable << 1;   // Shifts out to zero after last flit
					if (decide)
						state <= go ? icu_idle : icu_wait;
				end
				icu_wait:
				begin
					if (go)
						state <= icu_idle;
				end
				default:
					state <= icu_idle;
			endcase
		end
	end

	// At most one flit register written per cycle
	a_enable_onehot: assert property (@(posedge clk) disable iff (reset)
		$onehot0(register_enable_dout));

endmodule

`default_nettype wire

// ==== des_nic_pkg.sv ====
`default_nettype none

package des_nic_pkg;

	// ##################################################
	// Channel and packet format
	// ##################################################
	localparam int channel_width  = 32;   // Flit width
	localparam int data_flits     = 4;    // Plaintext hi/lo, key hi/lo
	localparam int reply_flits    = 3;    // Header, ciphertext hi, ciphertext lo
	localparam int cipher_rounds  = 16;   // Feistel rounds per block
	localparam int output_credits = 2;    // Reply buffers downstream at reset

	// Counter widths derived from the format
	localparam int round_count_width  = $clog2(cipher_rounds);
	localparam int credit_count_width = $clog2(output_credits + 1);   // Must hold 0..output_credits
	localparam int flit_index_width   = $clog2(reply_flits);

	// ##################################################
	// Flit decoding
	// ##################################################
	// One channel word, seen raw or as a header
	typedef union packed
	{
		logic [channel_width-1:0] data;   // Raw payload word
		struct packed
		{
			logic       header_field;     // Set on header flits only
			logic       done_flag;        // Zero on requests, one on replies
			logic [7:0] dest;             // Destination node
			logic [7:0] source;           // Source node
			logic [13:0] packet_id;
		} head;
	} des_flit_t;

	// ##################################################
	// FSM encodings
	// ##################################################
	typedef enum logic [1:0]
	{
		icu_idle,      // Waiting for a header
		icu_capture,   // Data flits streaming in, then decide
		icu_wait       // Packet held until engine and credits free
	} icu_state_t;

	typedef enum logic
	{
		obk_idle,   // Ready to take a result
		obk_send    // Serializing ciphertext flits
	} obk_state_t;

endpackage

`default_nettype wire

// ==== feistel_engine.sv ====
`timescale 1ns/100ps
`default_nettype none

module feistel_engine import des_nic_pkg::*;
(
	input  wire                          clk,
	input  wire                          reset,
	input  wire                          start,          // Round 0 runs on this edge
	input  wire  [2*channel_width-1:0]   plaintext,
	input  wire  [2*channel_width-1:0]   key,
	input  wire                          result_take,
	output logic                         busy,
	output logic                         result_valid,
	output logic [2*channel_width-1:0]   ciphertext
);

	logic [channel_width-1:0]     left;
	logic [channel_width-1:0]     right;
	logic [channel_width-1:0]     round_key;       // Key high word, rotated 4 per round
	logic [channel_width-1:0]     left_in;
	logic [channel_width-1:0]     right_in;
	logic [channel_width-1:0]     round_key_in;
	logic [round_count_width-1:0] round_count;     // Rounds done so far
	logic                         running;

	// XOR, rotate left by 3, add key
	function automatic logic [channel_width-1:0] round_function(
		input logic [channel_width-1:0] half,
		input logic [channel_width-1:0] rkey);
		logic [channel_width-1:0] mixed;
		mixed = half ^ rkey;
		return {mixed[channel_width-4:0], mixed[channel_width-1:channel_width-3]} + rkey;
	endfunction

	// Start feeds plaintext straight into round 0
	assign left_in      = start ? plaintext[2*channel_width-1:channel_width] : left;
	assign right_in     = start ? plaintext[channel_width-1:0] : right;
	assign round_key_in = start ? key[2*channel_width-1:channel_width] : round_key;

	// ##################################################
	// Round datapath, no reset
	// ##################################################
	always_ff @(posedge clk)
	begin
		if (start || running)
		begin
			left      <= right_in;
			right     <= left_in ^ round_function(right_in, round_key_in);
			round_key <= {round_key_in[channel_width-5:0], round_key_in[channel_width-1:channel_width-4]};
		end
	end

	// ##################################################
	// Round control
	// ##################################################
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			running      <= 1'b0;
			busy         <= 1'b0;
			result_valid <= 1'b0;
			round_count  <= '0;
		end
		else
		begin
			if (start)
			begin
				running     <= 1'b1;
				busy        <= 1'b1;
				round_count <= round_count_width'(1);
			end
			else if (running)
			begin
				round_count <= round_count + 1'b1;
				if (round_count == round_count_width'(cipher_rounds - 1))   // Last round
				begin
					running      <= 1'b0;
					result_valid <= 1'b1;
				end
			end
			if (result_take)   // Output block has the result
			begin
				result_valid <= 1'b0;
				busy         <= 1'b0;
			end
		end
	end

	assign ciphertext = {right, left};   // Final swap

	// One packet in the engine at a time
	a_no_start_busy: assert property (@(posedge clk) disable iff (reset) start |-> !busy);

endmodule

`default_nettype wire

// ==== input_block.sv ====
`timescale 1ns/100ps
`default_nettype none

module input_block import des_nic_pkg::*;
(
	input  wire                          clk,
	input  wire                          reset,
	input  wire  [channel_width-1:0]     input_channel_din,
	input  wire                          busy_engine_din,
	input  wire                          zero_credits_din,
	output logic [2*channel_width-1:0]   plaintext_dout,
	output logic [2*channel_width-1:0]   key_dout,
	output logic [channel_width-3:0]     header_flit_dout,         // Header of the packet in flight
	output logic                         transfer2pe_strobe_dout
);

	des_flit_t                channel_flit;                   // Channel word, decoded
	logic [data_flits:0]      register_enable;
	logic                     write_strobe;
	logic [channel_width-3:0] header_capture;                 // Header of the packet being received
	logic [channel_width-1:0] data_flit_bank [data_flits];

	assign channel_flit = input_channel_din;

	des_nic_input_control_unit i_control
	(
		.clk                     (clk),
		.reset                   (reset),
		.header_field_din        (channel_flit.head.header_field),
		.busy_engine_din         (busy_engine_din),
		.zero_credits_din        (zero_credits_din),
		.transfer2pe_strobe_dout (transfer2pe_strobe_dout),
		.write_strobe_dout       (write_strobe),
		.register_enable_dout    (register_enable)
	);

	// ##################################################
	// Capture registers
	// ##################################################
	always_ff @(posedge clk)
	begin
		// Header and done bits are rebuilt on reply
		if (register_enable[0] && write_strobe)
			header_capture <= {channel_flit.head.dest, channel_flit.head.source,
				channel_flit.head.packet_id};
		// Hand header over at start, next packet may then overwrite the capture
		if (transfer2pe_strobe_dout)
			header_flit_dout <= header_capture;
		for (int i = 0; i < data_flits; i++)
		begin
			if (register_enable[i+1] && write_strobe)
				data_flit_bank[i] <= input_channel_din;
		end
	end

	assign plaintext_dout = {data_flit_bank[0], data_flit_bank[1]};   // First flit is high word
	assign key_dout       = {data_flit_bank[2], data_flit_bank[3]};

endmodule

`default_nettype wire

// ==== output_block.sv ====
`timescale 1ns/100ps
`default_nettype none

module output_block import des_nic_pkg::*;
(
	input  wire                          clk,
	input  wire                          reset,
	input  wire                          result_valid,
	input  wire  [2*channel_width-1:0]   ciphertext,
	input  wire  [channel_width-3:0]     header_flit_din,
	input  wire                          credit_in,              // One reply buffer freed
	output logic                         result_take,
	output logic                         zero_credits_dout,
	output logic [channel_width-1:0]     output_channel_dout,
	output logic                         output_channel_valid
);

	obk_state_t                    state;
	des_flit_t                     reply_head;        // Header flit of the reply
	logic [2*channel_width-1:0]    cipher_reg;
	logic [flit_index_width-1:0]   flit_index;        // Next flit to put on the channel
	logic [credit_count_width-1:0] credit_count;

	// Take only with a credit in hand, header consumes it
	assign result_take       = (state == obk_idle) && result_valid && (credit_count != '0);
	assign zero_credits_dout = (credit_count == '0);

	always_comb
	begin
		reply_head.head.header_field = 1'b1;
		reply_head.head.done_flag    = 1'b1;   // Marks the packet as processed
		{reply_head.head.dest, reply_head.head.source, reply_head.head.packet_id} = header_flit_din;
	end

	// ##################################################
	// Reply serializer
	// ##################################################
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state                <= obk_idle;
			flit_index           <= '0;
			output_channel_valid <= 1'b0;
		end
		else
		begin
			case (state)
				obk_idle:
				begin
					output_channel_valid <= result_take;
					if (result_take)
					begin
						state      <= obk_send;
						flit_index <= flit_index_width'(1);   // Header goes out now
					end
				end
				obk_send:
				begin
					output_channel_valid <= 1'b1;
					flit_index           <= flit_index + 1'b1;
					if (flit_index == flit_index_width'(reply_flits - 1))   // Low word is last
						state <= obk_idle;
				end
				default:
					state <= obk_idle;
			endcase
		end
	end

	// Payload side, no reset
	always_ff @(posedge clk)
	begin
		if (result_take)
		begin
			output_channel_dout <= reply_head.data;
			cipher_reg          <= ciphertext;
		end
		else if (state == obk_send)
			output_channel_dout <= (flit_index == flit_index_width'(1)) ?
				cipher_reg[2*channel_width-1:channel_width] : cipher_reg[channel_width-1:0];
	end

	// ##################################################
	// Output credits, counted in packets
	// ##################################################
	always_ff @(posedge clk)
	begin
		if (reset)
			credit_count <= credit_count_width'(output_credits);
		else if (result_take && !credit_in)
			credit_count <= credit_count - 1'b1;
		else if (credit_in && !result_take)
			credit_count <= credit_count + 1'b1;
	end

	// Router never returns more buffers than it has
	a_credit_max: assert property (@(posedge clk) disable iff (reset)
		credit_count <= credit_count_width'(output_credits));

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_des_nic \
	-f compile.f -o sim_des_nic
./obj_dir/sim_des_nic > sim.log 2>&1 || true
cat sim.log

if grep -qx "TEST PASSED" sim.log; then
	exit 0
fi
echo "Simulation did not pass, see sim.log"
exit 1

// ==== tb_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_checker import des_nic_pkg::*;
(
	input  wire                       clk,
	input  wire                       reset,
	input  wire [channel_width-1:0]   input_channel_din,
	input  wire                       input_credit,
	input  wire                       credit_in,
	input  wire [channel_width-1:0]   output_channel_dout,
	input  wire                       output_channel_valid,
	input  wire                       end_of_test,        // Run the closing checks
	input  int                        packets_sent,
	output int                        value_errors,
	output int                        protocol_errors,
	output int                        replies_checked,
	output logic                      checks_done
);

	logic [channel_width-3:0]   head_q [$];          // Expected reply headers in request order
	logic [2*channel_width-1:0] cipher_q [$];        // Expected ciphertexts in the same order
	logic [channel_width-1:0]   cap_data [data_flits];
	logic [channel_width-3:0]   cap_head;
	logic [channel_width-3:0]   exp_head;
	logic [2*channel_width-1:0] exp_cipher;
	des_flit_t                  in_flit;
	des_flit_t                  out_flit;
	int                         in_pos;              // Next data flit 1..4 or 0 when idle
	int                         out_pos;             // Flit index within a reply
	int                         captured;
	int                         started;             // input_credit pulses seen
	int                         headers_sent;
	int                         credits_back;        // credit_in pulses seen
	bit                         matched;             // Reply has a request to compare with

	// ##################################################
	// Reference cipher
	// ##################################################
	function automatic logic [31:0] rotate_left(input logic [31:0] word, input int amount);
		int n;
		n = amount % 32;
		return (word << n) | (word >> (32 - n));   // Shift by 32 gives zero
	endfunction

	// 16 Feistel rounds with f(x) = rotl(x ^ k, 3) + k
	function automatic logic [63:0] encrypt_block(input logic [63:0] block,
		input logic [63:0] key);
		logic [31:0] l;
		logic [31:0] r;
		logic [31:0] k;
		logic [31:0] f;
		l = block[63:32];
		r = block[31:0];
		for (int i = 0; i < cipher_rounds; i++)
		begin
			k = rotate_left(key[63:32], 4 * i);   // Key high word rotated 4 more per round
			f = rotate_left(r ^ k, 3) + k;
			{l, r} = {r, l ^ f};
		end
		return {r, l};   // Halves swapped at the end
	endfunction

	task automatic report_mismatch(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		value_errors++;
		$display("[FAIL] %0d ns %s expected %h actual %h", $time, name, expected, actual);
	endtask

	task automatic report_protocol(input string what);
		protocol_errors++;
		$display("Protocol error at %0d ns: %s", $time, what);
	endtask

	// ##################################################
	// Monitor sampled mid-cycle
	// ##################################################
	always @(negedge clk)
	begin
		in_flit  = input_channel_din;
		out_flit = output_channel_dout;
		if (reset)
		begin
			value_errors    = 0;
			protocol_errors = 0;
			replies_checked = 0;
			checks_done     = 1'b0;
			in_pos          = 0;
			out_pos         = 0;
			captured        = 0;
			started         = 0;
			headers_sent    = 0;
			credits_back    = 0;
		end
		else
		begin
			// Request framing is a header then four data flits
			if (in_pos == 0)
			begin
				if (in_flit.head.header_field)
				begin
					cap_head = in_flit.data[channel_width-3:0];
					in_pos   = 1;
				end
			end
			else
			begin
				cap_data[in_pos-1] = in_flit.data;
				if (in_pos == data_flits)   // Packet complete
				begin
					head_q.push_back(cap_head);
					cipher_q.push_back(encrypt_block({cap_data[0], cap_data[1]},
						{cap_data[2], cap_data[3]}));
					captured++;
					in_pos = 0;
				end
				else
					in_pos++;
			end

			if (input_credit)
			begin
				if (started >= captured)
					report_protocol("input credit returned with no packet captured");
				started++;
			end
			if (credit_in)
				credits_back++;

			// Reply flits
			if (output_channel_valid)
			begin
				case (out_pos)
					0:
					begin
						matched = (head_q.size() != 0);
						if (matched)
						begin
							exp_head   = head_q.pop_front();
							exp_cipher = cipher_q.pop_front();
						end
						else
							report_protocol("reply header sent with no request outstanding");
						headers_sent++;
						if (headers_sent > output_credits + credits_back)
							report_protocol("reply sent without a downstream credit");
						if (out_flit.head.header_field !== 1'b1)
							report_mismatch("output_channel_dout.header_field", 64'(1),
								64'(out_flit.head.header_field));
						if (out_flit.head.done_flag !== 1'b1)
							report_mismatch("output_channel_dout.done_flag", 64'(1),
								64'(out_flit.head.done_flag));
						if (matched && {out_flit.head.dest, out_flit.head.source,
							out_flit.head.packet_id} !== exp_head)
							report_mismatch("output_channel_dout header", 64'(exp_head),
								64'(out_flit.data[channel_width-3:0]));
						out_pos = 1;
					end
					1:
					begin
						if (matched && out_flit.data !== exp_cipher[63:32])
							report_mismatch("output_channel_dout cipher high",
								64'(exp_cipher[63:32]), 64'(out_flit.data));
						out_pos = 2;
					end
					default:
					begin
						if (matched && out_flit.data !== exp_cipher[31:0])
							report_mismatch("output_channel_dout cipher low",
								64'(exp_cipher[31:0]), 64'(out_flit.data));
						replies_checked++;
						out_pos = 0;
					end
				endcase
			end
			else if (out_pos != 0)   // Gap inside a reply
			begin
				report_protocol("reply flits not on consecutive cycles");
				out_pos = 0;
			end

			// Closing checks run once
			if (end_of_test && !checks_done)
			begin
				if (in_pos != 0)
					report_protocol("request packet left incomplete");
				if (captured != packets_sent)
					report_protocol($sformatf("captured %0d packets, %0d were sent",
						captured, packets_sent));
				if (started != captured)
					report_protocol($sformatf("input credit pulsed %0d times for %0d packets",
						started, captured));
				if (head_q.size() != 0)
					report_protocol($sformatf("%0d replies never sent", head_q.size()));
				checks_done = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== tb_des_nic.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_des_nic import des_nic_pkg::*;
();

	localparam int packet_count      = 200;
	localparam int clock_period      = 20;    // ns
	localparam int reset_cycles      = 8;
	localparam int cycles_per_packet = 120;   // Watchdog budget
	localparam int max_gap           = 6;     // Idle words before a packet
	localparam int max_credit_delay  = 40;
	localparam int withhold_cycles   = 300;   // Long stall on the router side
	localparam int drain_cycles      = 50;

	logic                     clk;
	logic                     reset;
	logic [channel_width-1:0] input_channel_din;
	logic                     credit_in;
	logic                     input_credit;
	logic [channel_width-1:0] output_channel_dout;
	logic                     output_channel_valid;
	logic                     end_of_test;
	logic                     checks_done;
	int                       packets_sent;
	int                       value_errors;
	int                       protocol_errors;
	int                       replies_checked;
	int                       credits_owed = 0;     // Replies whose buffer is not yet freed
	int                       reply_flit_pos = 0;
	bit                       credit_held;          // Router's single input credit

	des_nic i_dut
	(
		.clk                  (clk),
		.reset                (reset),
		.input_channel_din    (input_channel_din),
		.credit_in            (credit_in),
		.input_credit         (input_credit),
		.output_channel_dout  (output_channel_dout),
		.output_channel_valid (output_channel_valid)
	);

	tb_checker i_checker
	(
		.clk                  (clk),
		.reset                (reset),
		.input_channel_din    (input_channel_din),
		.input_credit         (input_credit),
		.credit_in            (credit_in),
		.output_channel_dout  (output_channel_dout),
		.output_channel_valid (output_channel_valid),
		.end_of_test          (end_of_test),
		.packets_sent         (packets_sent),
		.value_errors         (value_errors),
		.protocol_errors      (protocol_errors),
		.replies_checked      (replies_checked),
		.checks_done          (checks_done)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clock_period / 2) clk = ~clk;
	end

	// Whole run must fit the budget
	initial
	begin
		#((packet_count * cycles_per_packet + reset_cycles) * clock_period);
		$display("Watchdog expired: replies still missing after %0d packets", packets_sent);
		$display("TEST FAILED");
		$finish;
	end

	// ##################################################
	// Router side
	// ##################################################
	// One word per cycle with the input credit sampled mid-cycle
	task automatic send_word(input logic [channel_width-1:0] word);
		@(posedge clk);
		input_channel_din <= word;
		@(negedge clk);
		if (input_credit)
			credit_held = 1'b1;
	endtask

	function automatic logic [channel_width-1:0] idle_word();
		logic [channel_width-1:0] word;
		word     = $urandom();
		word[31] = 1'b0;   // Never looks like a header
		return word;
	endfunction

	function automatic logic [channel_width-1:0] request_header();
		des_flit_t flit;
		flit.data              = $urandom();
		flit.head.header_field = 1'b1;
		flit.head.done_flag    = 1'b0;
		return flit.data;
	endfunction

	// Count reply packets arriving
	always @(negedge clk)
	begin
		if (!reset && output_channel_valid)
		begin
			if (reply_flit_pos == 0)
				credits_owed++;
			reply_flit_pos = (reply_flit_pos + 1) % reply_flits;
		end
	end

	// Free buffers after a random and sometimes long delay
	initial
	begin
		int delay;
		forever
		begin
			@(posedge clk);
			if (credits_owed > 0)
			begin
				delay = $urandom_range(max_credit_delay, 0);
				if ($urandom_range(15, 0) == 0)
					delay = delay + withhold_cycles;
				repeat (delay) @(posedge clk);
				credit_in <= 1'b1;   // One-cycle pulse
				credits_owed--;
				@(posedge clk);
				credit_in <= 1'b0;
			end
		end
	end

	// ##################################################
	// Stimulus
	// ##################################################
	initial
	begin
		int gap;
		void'($urandom(32'hf283));
		reset             = 1'b1;
		input_channel_din = '0;
		credit_in         = 1'b0;
		end_of_test       = 1'b0;
		packets_sent      = 0;
		credit_held       = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		reset <= 1'b0;

		for (int p = 0; p < packet_count; p++)
		begin
			gap = $urandom_range(max_gap, 0);
			repeat (gap) send_word(idle_word());
			while (!credit_held)   // Wait for the input buffer
				send_word(idle_word());
			credit_held = 1'b0;
			send_word(request_header());
			repeat (data_flits) send_word($urandom());
			packets_sent++;
		end

		while (replies_checked < packet_count)
			send_word(idle_word());
		repeat (drain_cycles) send_word(idle_word());   // Catch stray replies

		@(posedge clk);
		end_of_test <= 1'b1;
		while (!checks_done)
			@(posedge clk);

		$display("Errors: %0d value, %0d protocol, %0d replies checked",
			value_errors, protocol_errors, replies_checked);
		if (value_errors == 0 && protocol_errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire
